// File: Bender.yml
package:
  name: rs_station

sources:
  - common/rs_pkg.sv
  - source/rs_dispatch_alloc.sv
  - source/rs_entry_array.sv
  - source/rs_issue_select.sv
  - source/rs_top.sv
  - target: test
    files:
      - verification/rs_asserts.sv
      - verification/rs_tb.sv

// File: build.f
common/rs_pkg.sv
source/rs_dispatch_alloc.sv
source/rs_entry_array.sv
source/rs_issue_select.sv
source/rs_top.sv
verification/rs_asserts.sv
verification/rs_tb.sv

// File: common/rs_pkg.sv
package rs_pkg;

    // station geometry
    localparam int RS_DEPTH = 8;
    localparam int DISPATCH_WIDTH = 2;
    localparam int CDB_WIDTH = 2;

    // functional units per class
    localparam int NUM_ALU = 2;
    localparam int NUM_MULT = 1;

    // tag widths
    localparam int PREG_BITS = 6;
    localparam int INST_TAG_BITS = 8;

    // physical register tag
    typedef logic [PREG_BITS-1:0] preg_t;

    // instruction id, carried through for identification only
    typedef logic [INST_TAG_BITS-1:0] inst_tag_t;

    // class selector
    typedef logic [0:0] fu_type_t;

    // one bit per station entry
    typedef logic [RS_DEPTH-1:0] slot_vec_t;

    // 0 up to DISPATCH_WIDTH
    typedef logic [$clog2(DISPATCH_WIDTH + 1)-1:0] open_count_t;

    // class codes
    localparam fu_type_t FU_ALU = 1'b0;
    localparam fu_type_t FU_MULT = 1'b1;

endpackage

// File: source/rs_dispatch_alloc.sv
`timescale 1ns/1ps

module rs_dispatch_alloc (
    input  logic                disp_valid [rs_pkg::DISPATCH_WIDTH],
    input  rs_pkg::slot_vec_t   free_slots,
    output rs_pkg::slot_vec_t   alloc_grant [rs_pkg::DISPATCH_WIDTH],
    output rs_pkg::open_count_t open_entries
);

    // free set still available to the lane being handled
    rs_pkg::slot_vec_t remaining;

    // number of free slots, before saturation
    int free_count;

    // lane 0 gets first pick, each later lane sees what is left
    always_comb begin
        remaining = free_slots;
        for (int lane = 0; lane < rs_pkg::DISPATCH_WIDTH; lane++) begin
            alloc_grant[lane] = '0;
            if (disp_valid[lane]) begin
                // isolate lowest set bit
                alloc_grant[lane] = remaining & (~remaining + 1'b1);
            end
            remaining = remaining & ~alloc_grant[lane];
        end
    end

    // open entries seen by the front end, capped at the lane count
    always_comb begin
        free_count = 0;
        for (int s = 0; s < rs_pkg::RS_DEPTH; s++) begin
            if (free_slots[s]) begin
                free_count = free_count + 1;
            end
        end
        if (free_count > rs_pkg::DISPATCH_WIDTH) begin
            open_entries = rs_pkg::open_count_t'(rs_pkg::DISPATCH_WIDTH);
        end else begin
            open_entries = rs_pkg::open_count_t'(free_count);
        end
    end

endmodule

// File: source/rs_entry_array.sv
`timescale 1ns/1ps

module rs_entry_array (
    input  logic                clock,
    input  logic                reset,

    input  rs_pkg::fu_type_t    disp_fu_type [rs_pkg::DISPATCH_WIDTH],
    input  rs_pkg::inst_tag_t   disp_tag [rs_pkg::DISPATCH_WIDTH],
    input  rs_pkg::preg_t       disp_dest [rs_pkg::DISPATCH_WIDTH],
    input  rs_pkg::preg_t       disp_src1 [rs_pkg::DISPATCH_WIDTH],
    input  logic                disp_src1_ready [rs_pkg::DISPATCH_WIDTH],
    input  rs_pkg::preg_t       disp_src2 [rs_pkg::DISPATCH_WIDTH],
    input  logic                disp_src2_ready [rs_pkg::DISPATCH_WIDTH],
    input  rs_pkg::slot_vec_t   alloc_grant [rs_pkg::DISPATCH_WIDTH],

    input  logic                cdb_valid [rs_pkg::CDB_WIDTH],
    input  rs_pkg::preg_t       cdb_preg [rs_pkg::CDB_WIDTH],

    input  rs_pkg::slot_vec_t   issued_slots,

    output rs_pkg::slot_vec_t   free_slots,
    output rs_pkg::slot_vec_t   ready_alu,
    output rs_pkg::slot_vec_t   ready_mult,
    output rs_pkg::inst_tag_t   entry_tag [rs_pkg::RS_DEPTH],
    output rs_pkg::preg_t       entry_dest [rs_pkg::RS_DEPTH]
);

    rs_pkg::slot_vec_t entry_valid, next_valid;
    rs_pkg::slot_vec_t src1_rdy, next_src1_rdy;
    rs_pkg::slot_vec_t src2_rdy, next_src2_rdy;
    rs_pkg::fu_type_t  entry_fu [rs_pkg::RS_DEPTH];
    rs_pkg::preg_t     entry_src1 [rs_pkg::RS_DEPTH];
    rs_pkg::preg_t     entry_src2 [rs_pkg::RS_DEPTH];

    always_comb begin
        next_valid = entry_valid & ~issued_slots;
        next_src1_rdy = src1_rdy;
        next_src2_rdy = src2_rdy;

        // wakeup of stored entries from the broadcast lanes
        for (int s = 0; s < rs_pkg::RS_DEPTH; s++) begin
            for (int l = 0; l < rs_pkg::CDB_WIDTH; l++) begin
                if (entry_valid[s] && cdb_valid[l]) begin
                    if (entry_src1[s] == cdb_preg[l]) begin
                        next_src1_rdy[s] = 1'b1;
                    end
                    if (entry_src2[s] == cdb_preg[l]) begin
                        next_src2_rdy[s] = 1'b1;
                    end
                end
            end
        end

        // new entries take the front end's ready bits as they are
        for (int lane = 0; lane < rs_pkg::DISPATCH_WIDTH; lane++) begin
            next_valid = next_valid | alloc_grant[lane];
            for (int s = 0; s < rs_pkg::RS_DEPTH; s++) begin
                if (alloc_grant[lane][s]) begin
                    next_src1_rdy[s] = disp_src1_ready[lane];
                    next_src2_rdy[s] = disp_src2_ready[lane];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
        end else begin
            entry_valid <= next_valid;
        end
    end

    always_ff @(posedge clock) begin
        src1_rdy <= next_src1_rdy;
        src2_rdy <= next_src2_rdy;
        for (int lane = 0; lane < rs_pkg::DISPATCH_WIDTH; lane++) begin
            for (int s = 0; s < rs_pkg::RS_DEPTH; s++) begin
                if (alloc_grant[lane][s]) begin
                    entry_fu[s] <= disp_fu_type[lane];
                    entry_tag[s] <= disp_tag[lane];
                    entry_dest[s] <= disp_dest[lane];
                    entry_src1[s] <= disp_src1[lane];
                    entry_src2[s] <= disp_src2[lane];
                end
            end
        end
    end

    assign free_slots = ~entry_valid;

    // ready per class, both sources present
    always_comb begin
        for (int s = 0; s < rs_pkg::RS_DEPTH; s++) begin
            ready_alu[s] = entry_valid[s] && src1_rdy[s] && src2_rdy[s]
                && (entry_fu[s] == rs_pkg::FU_ALU);
            ready_mult[s] = entry_valid[s] && src1_rdy[s] && src2_rdy[s]
                && (entry_fu[s] == rs_pkg::FU_MULT);
        end
    end

endmodule

// File: source/rs_issue_select.sv
`timescale 1ns/1ps

module rs_issue_select (
    input  rs_pkg::slot_vec_t   ready_alu,
    input  rs_pkg::slot_vec_t   ready_mult,
    input  rs_pkg::inst_tag_t   entry_tag [rs_pkg::RS_DEPTH],
    input  rs_pkg::preg_t       entry_dest [rs_pkg::RS_DEPTH],
    input  logic [rs_pkg::NUM_ALU-1:0]  alu_busy,
    input  logic [rs_pkg::NUM_MULT-1:0] mult_busy,

    output logic                alu_issue_valid [rs_pkg::NUM_ALU],
    output rs_pkg::inst_tag_t   alu_issue_tag [rs_pkg::NUM_ALU],
    output rs_pkg::preg_t       alu_issue_dest [rs_pkg::NUM_ALU],
    output logic                mult_issue_valid [rs_pkg::NUM_MULT],
    output rs_pkg::inst_tag_t   mult_issue_tag [rs_pkg::NUM_MULT],
    output rs_pkg::preg_t       mult_issue_dest [rs_pkg::NUM_MULT],

    output rs_pkg::slot_vec_t   issued_slots
);

    rs_pkg::slot_vec_t alu_left, alu_taken;
    rs_pkg::slot_vec_t mult_left, mult_taken;
    rs_pkg::slot_vec_t alu_grant [rs_pkg::NUM_ALU];
    rs_pkg::slot_vec_t mult_grant [rs_pkg::NUM_MULT];

    // one-hot of the lowest set bit, zero if none
    function automatic rs_pkg::slot_vec_t lowest_slot(input rs_pkg::slot_vec_t v);
        return v & (~v + 1'b1);
    endfunction

    // grant is one-hot or zero
    function automatic rs_pkg::inst_tag_t pick_tag(
        input rs_pkg::slot_vec_t grant,
        input rs_pkg::inst_tag_t tags [rs_pkg::RS_DEPTH]
    );
        rs_pkg::inst_tag_t result;
        result = '0;
        for (int s = 0; s < rs_pkg::RS_DEPTH; s++) begin
            if (grant[s]) begin
                result = tags[s];
            end
        end
        return result;
    endfunction

    function automatic rs_pkg::preg_t pick_dest(
        input rs_pkg::slot_vec_t grant,
        input rs_pkg::preg_t dests [rs_pkg::RS_DEPTH]
    );
        rs_pkg::preg_t result;
        result = '0;
        for (int s = 0; s < rs_pkg::RS_DEPTH; s++) begin
            if (grant[s]) begin
                result = dests[s];
            end
        end
        return result;
    endfunction

    // units in ascending order, each free one takes the lowest ready slot left
    always_comb begin
        alu_left = ready_alu;
        alu_taken = '0;
        for (int u = 0; u < rs_pkg::NUM_ALU; u++) begin
            alu_grant[u] = alu_busy[u] ? '0 : lowest_slot(alu_left);
            alu_left = alu_left & ~alu_grant[u];
            alu_taken = alu_taken | alu_grant[u];
        end

        mult_left = ready_mult;
        mult_taken = '0;
        for (int u = 0; u < rs_pkg::NUM_MULT; u++) begin
            mult_grant[u] = mult_busy[u] ? '0 : lowest_slot(mult_left);
            mult_left = mult_left & ~mult_grant[u];
            mult_taken = mult_taken | mult_grant[u];
        end
    end

    always_comb begin
        for (int u = 0; u < rs_pkg::NUM_ALU; u++) begin
            alu_issue_valid[u] = |alu_grant[u];
            alu_issue_tag[u] = pick_tag(alu_grant[u], entry_tag);
            alu_issue_dest[u] = pick_dest(alu_grant[u], entry_dest);
        end
        for (int u = 0; u < rs_pkg::NUM_MULT; u++) begin
            mult_issue_valid[u] = |mult_grant[u];
            mult_issue_tag[u] = pick_tag(mult_grant[u], entry_tag);
            mult_issue_dest[u] = pick_dest(mult_grant[u], entry_dest);
        end
    end

    // slots freed at the end of this cycle
    assign issued_slots = alu_taken | mult_taken;

endmodule

// File: source/rs_top.sv
`timescale 1ns/1ps

module rs_top (
    input  logic                clock,
    input  logic                reset,

    // dispatch lanes
    input  logic                disp_valid [rs_pkg::DISPATCH_WIDTH],
    input  rs_pkg::fu_type_t    disp_fu_type [rs_pkg::DISPATCH_WIDTH],
    input  rs_pkg::inst_tag_t   disp_tag [rs_pkg::DISPATCH_WIDTH],
    input  rs_pkg::preg_t       disp_dest [rs_pkg::DISPATCH_WIDTH],
    input  rs_pkg::preg_t       disp_src1 [rs_pkg::DISPATCH_WIDTH],
    input  logic                disp_src1_ready [rs_pkg::DISPATCH_WIDTH],
    input  rs_pkg::preg_t       disp_src2 [rs_pkg::DISPATCH_WIDTH],
    input  logic                disp_src2_ready [rs_pkg::DISPATCH_WIDTH],

    // result broadcast
    input  logic                cdb_valid [rs_pkg::CDB_WIDTH],
    input  rs_pkg::preg_t       cdb_preg [rs_pkg::CDB_WIDTH],

    // unit busy levels
    input  logic [rs_pkg::NUM_ALU-1:0]  alu_busy,
    input  logic [rs_pkg::NUM_MULT-1:0] mult_busy,

    // issue ports
    output logic                alu_issue_valid [rs_pkg::NUM_ALU],
    output rs_pkg::inst_tag_t   alu_issue_tag [rs_pkg::NUM_ALU],
    output rs_pkg::preg_t       alu_issue_dest [rs_pkg::NUM_ALU],
    output logic                mult_issue_valid [rs_pkg::NUM_MULT],
    output rs_pkg::inst_tag_t   mult_issue_tag [rs_pkg::NUM_MULT],
    output rs_pkg::preg_t       mult_issue_dest [rs_pkg::NUM_MULT],

    output rs_pkg::open_count_t open_entries
);

    rs_pkg::slot_vec_t free_slots;
    rs_pkg::slot_vec_t alloc_grant [rs_pkg::DISPATCH_WIDTH];
    rs_pkg::slot_vec_t ready_alu;
    rs_pkg::slot_vec_t ready_mult;
    rs_pkg::slot_vec_t issued_slots;
    rs_pkg::inst_tag_t entry_tag [rs_pkg::RS_DEPTH];
    rs_pkg::preg_t     entry_dest [rs_pkg::RS_DEPTH];

    rs_dispatch_alloc alloc0 (
        .disp_valid   (disp_valid),
        .free_slots   (free_slots),
        .alloc_grant  (alloc_grant),
        .open_entries (open_entries)
    );

    rs_entry_array array0 (
        .clock           (clock),
        .reset           (reset),
        .disp_fu_type    (disp_fu_type),
        .disp_tag        (disp_tag),
        .disp_dest       (disp_dest),
        .disp_src1       (disp_src1),
        .disp_src1_ready (disp_src1_ready),
        .disp_src2       (disp_src2),
        .disp_src2_ready (disp_src2_ready),
        .alloc_grant     (alloc_grant),
        .cdb_valid       (cdb_valid),
        .cdb_preg        (cdb_preg),
        .issued_slots    (issued_slots),
        .free_slots      (free_slots),
        .ready_alu       (ready_alu),
        .ready_mult      (ready_mult),
        .entry_tag       (entry_tag),
        .entry_dest      (entry_dest)
    );

    rs_issue_select select0 (
        .ready_alu        (ready_alu),
        .ready_mult       (ready_mult),
        .entry_tag        (entry_tag),
        .entry_dest       (entry_dest),
        .alu_busy         (alu_busy),
        .mult_busy        (mult_busy),
        .alu_issue_valid  (alu_issue_valid),
        .alu_issue_tag    (alu_issue_tag),
        .alu_issue_dest   (alu_issue_dest),
        .mult_issue_valid (mult_issue_valid),
        .mult_issue_tag   (mult_issue_tag),
        .mult_issue_dest  (mult_issue_dest),
        .issued_slots     (issued_slots)
    );

endmodule

// File: verification/rs_asserts.sv
`timescale 1ns/1ps

module rs_asserts (
    input logic                        clock,
    input logic                        reset,
    input logic                        disp_valid [rs_pkg::DISPATCH_WIDTH],
    input logic [rs_pkg::NUM_ALU-1:0]  alu_busy,
    input logic [rs_pkg::NUM_MULT-1:0] mult_busy,
    input logic                        alu_issue_valid [rs_pkg::NUM_ALU],
    input logic                        mult_issue_valid [rs_pkg::NUM_MULT],
    input rs_pkg::open_count_t         open_entries
);

    // goes high once any property fails
    logic violation = 1'b0;
    int lanes_valid;
    logic busy_issue;

    always_comb begin
        lanes_valid = 0;
        busy_issue = 1'b0;
        for (int l = 0; l < rs_pkg::DISPATCH_WIDTH; l++) begin
            lanes_valid = lanes_valid + (disp_valid[l] ? 1 : 0);
        end
        for (int u = 0; u < rs_pkg::NUM_ALU; u++) begin
            busy_issue = busy_issue | (alu_issue_valid[u] & alu_busy[u]);
        end
        for (int u = 0; u < rs_pkg::NUM_MULT; u++) begin
            busy_issue = busy_issue | (mult_issue_valid[u] & mult_busy[u]);
        end
    end

    lanes_within_open: assert property (@(posedge clock) disable iff (reset)
        lanes_valid <= int'(open_entries))
        else begin
            $error("more dispatch lanes valid than open entries");
            violation = 1'b1;
        end

    no_issue_to_busy: assert property (@(posedge clock) disable iff (reset) !busy_issue)
        else begin
            $error("issue valid high on a busy unit");
            violation = 1'b1;
        end

    open_within_width: assert property (@(posedge clock) disable iff (reset)
        int'(open_entries) <= rs_pkg::DISPATCH_WIDTH)
        else begin
            $error("open_entries above dispatch width");
            violation = 1'b1;
        end

endmodule

bind rs_top rs_asserts asserts0 (.*);

// File: verification/rs_tb.sv
`timescale 1ns/1ps

module rs_tb;

    localparam logic [31:0] SEED = 32'h8f22_022f;
    localparam int PERIOD_NS = 100;
    // about 40 cycles of tests, the rest is margin
    localparam int TIMEOUT_CYCLES = 400;

    logic clock;
    logic reset;
    logic disp_valid [rs_pkg::DISPATCH_WIDTH];
    rs_pkg::fu_type_t disp_fu_type [rs_pkg::DISPATCH_WIDTH];
    rs_pkg::inst_tag_t disp_tag [rs_pkg::DISPATCH_WIDTH];
    rs_pkg::preg_t disp_dest [rs_pkg::DISPATCH_WIDTH];
    rs_pkg::preg_t disp_src1 [rs_pkg::DISPATCH_WIDTH];
    logic disp_src1_ready [rs_pkg::DISPATCH_WIDTH];
    rs_pkg::preg_t disp_src2 [rs_pkg::DISPATCH_WIDTH];
    logic disp_src2_ready [rs_pkg::DISPATCH_WIDTH];
    logic cdb_valid [rs_pkg::CDB_WIDTH];
    rs_pkg::preg_t cdb_preg [rs_pkg::CDB_WIDTH];
    logic [rs_pkg::NUM_ALU-1:0] alu_busy;
    logic [rs_pkg::NUM_MULT-1:0] mult_busy;
    logic alu_issue_valid [rs_pkg::NUM_ALU];
    rs_pkg::inst_tag_t alu_issue_tag [rs_pkg::NUM_ALU];
    rs_pkg::preg_t alu_issue_dest [rs_pkg::NUM_ALU];
    logic mult_issue_valid [rs_pkg::NUM_MULT];
    rs_pkg::inst_tag_t mult_issue_tag [rs_pkg::NUM_MULT];
    rs_pkg::preg_t mult_issue_dest [rs_pkg::NUM_MULT];
    rs_pkg::open_count_t open_entries;

    // slot-level model of the station
    logic model_valid [rs_pkg::RS_DEPTH];
    logic model_r1 [rs_pkg::RS_DEPTH];
    logic model_r2 [rs_pkg::RS_DEPTH];
    rs_pkg::fu_type_t model_fu [rs_pkg::RS_DEPTH];
    rs_pkg::inst_tag_t model_tag [rs_pkg::RS_DEPTH];
    rs_pkg::preg_t model_dest [rs_pkg::RS_DEPTH];
    rs_pkg::preg_t model_src1 [rs_pkg::RS_DEPTH];
    rs_pkg::preg_t model_src2 [rs_pkg::RS_DEPTH];
    int alu_pick [rs_pkg::NUM_ALU];
    int mult_pick [rs_pkg::NUM_MULT];
    int cycles = 0;

    rs_top dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // a failed bound assertion also ends the run
    always @(negedge clock) begin
        if (dut0.asserts0.violation === 1'b1) begin
            abort_run("a protocol assertion in rs_asserts failed");
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_issue(
        input string unit_class, input int unit,
        input logic got_valid, input rs_pkg::inst_tag_t got_tag, input rs_pkg::preg_t got_dest,
        input logic exp_valid, input rs_pkg::inst_tag_t exp_tag, input rs_pkg::preg_t exp_dest
    );
        if (got_valid !== exp_valid) begin
            abort_run($sformatf("** Error: %s_issue_valid[%0d] = 0x%0h, expected 0x%0h",
                unit_class, unit, got_valid, exp_valid));
        end else if (exp_valid && got_tag !== exp_tag) begin
            abort_run($sformatf("** Error: %s_issue_tag[%0d] = 0x%0h, expected 0x%0h",
                unit_class, unit, got_tag, exp_tag));
        end else if (exp_valid && got_dest !== exp_dest) begin
            abort_run($sformatf("** Error: %s_issue_dest[%0d] = 0x%0h, expected 0x%0h",
                unit_class, unit, got_dest, exp_dest));
        end
    endtask

    task automatic check_open(input rs_pkg::open_count_t got, input rs_pkg::open_count_t expected);
        if (got !== expected) begin
            abort_run($sformatf("** Error: open_entries = 0x%0h, expected 0x%0h", got, expected));
        end
    endtask

    function automatic rs_pkg::preg_t random_preg();
        return rs_pkg::preg_t'($urandom());
    endfunction

    function automatic int count_free();
        int n;
        n = 0;
        for (int s = 0; s < rs_pkg::RS_DEPTH; s++) begin
            n = n + (model_valid[s] ? 0 : 1);
        end
        return n;
    endfunction

    function automatic int first_free(input int after);
        for (int s = after + 1; s < rs_pkg::RS_DEPTH; s++) begin
            if (!model_valid[s]) begin
                return s;
            end
        end
        return -1;
    endfunction

    function automatic int first_ready(input rs_pkg::fu_type_t fu, input int after);
        for (int s = after + 1; s < rs_pkg::RS_DEPTH; s++) begin
            if (model_valid[s] && model_r1[s] && model_r2[s] && model_fu[s] == fu) begin
                return s;
            end
        end
        return -1;
    endfunction

    // free units in ascending order take ready slots in ascending order
    task automatic predict_issue();
        int last;
        last = -1;
        for (int u = 0; u < rs_pkg::NUM_ALU; u++) begin
            alu_pick[u] = alu_busy[u] ? -1 : first_ready(rs_pkg::FU_ALU, last);
            last = (alu_pick[u] >= 0) ? alu_pick[u] : last;
        end
        last = -1;
        for (int u = 0; u < rs_pkg::NUM_MULT; u++) begin
            mult_pick[u] = mult_busy[u] ? -1 : first_ready(rs_pkg::FU_MULT, last);
            last = (mult_pick[u] >= 0) ? mult_pick[u] : last;
        end
    endtask

    // mid-cycle compare of every output against the model
    task automatic settle();
        int free_count;
        int pick;
        @(negedge clock);
        predict_issue();
        free_count = count_free();
        if (free_count > rs_pkg::DISPATCH_WIDTH) begin
            free_count = rs_pkg::DISPATCH_WIDTH;
        end
        check_open(open_entries, rs_pkg::open_count_t'(free_count));
        for (int u = 0; u < rs_pkg::NUM_ALU; u++) begin
            pick = (alu_pick[u] < 0) ? 0 : alu_pick[u];
            check_issue("alu", u, alu_issue_valid[u], alu_issue_tag[u], alu_issue_dest[u],
                alu_pick[u] >= 0, model_tag[pick], model_dest[pick]);
        end
        for (int u = 0; u < rs_pkg::NUM_MULT; u++) begin
            pick = (mult_pick[u] < 0) ? 0 : mult_pick[u];
            check_issue("mult", u, mult_issue_valid[u], mult_issue_tag[u], mult_issue_dest[u],
                mult_pick[u] >= 0, model_tag[pick], model_dest[pick]);
        end
    endtask

    // model update at the edge, then lanes go idle
    task automatic advance();
        int grant [rs_pkg::DISPATCH_WIDTH];
        int slot;
        @(posedge clock);
        predict_issue();
        slot = -1;
        for (int lane = 0; lane < rs_pkg::DISPATCH_WIDTH; lane++) begin
            grant[lane] = -1;
            if (disp_valid[lane]) begin
                slot = first_free(slot);
                grant[lane] = slot;
            end
        end
        for (int u = 0; u < rs_pkg::NUM_ALU; u++) begin
            if (alu_pick[u] >= 0) begin
                model_valid[alu_pick[u]] = 1'b0;
            end
        end
        for (int u = 0; u < rs_pkg::NUM_MULT; u++) begin
            if (mult_pick[u] >= 0) begin
                model_valid[mult_pick[u]] = 1'b0;
            end
        end
        for (int s = 0; s < rs_pkg::RS_DEPTH; s++) begin
            for (int l = 0; l < rs_pkg::CDB_WIDTH; l++) begin
                if (model_valid[s] && cdb_valid[l] && model_src1[s] == cdb_preg[l]) begin
                    model_r1[s] = 1'b1;
                end
                if (model_valid[s] && cdb_valid[l] && model_src2[s] == cdb_preg[l]) begin
                    model_r2[s] = 1'b1;
                end
            end
        end
        for (int lane = 0; lane < rs_pkg::DISPATCH_WIDTH; lane++) begin
            if (grant[lane] >= 0) begin
                slot = grant[lane];
                model_valid[slot] = 1'b1;
                model_fu[slot] = disp_fu_type[lane];
                model_tag[slot] = disp_tag[lane];
                model_dest[slot] = disp_dest[lane];
                model_src1[slot] = disp_src1[lane];
                model_src2[slot] = disp_src2[lane];
                model_r1[slot] = disp_src1_ready[lane];
                model_r2[slot] = disp_src2_ready[lane];
            end
            disp_valid[lane] <= 1'b0;
        end
        for (int l = 0; l < rs_pkg::CDB_WIDTH; l++) begin
            cdb_valid[l] <= 1'b0;
        end
    endtask

    task automatic step();
        settle();
        advance();
    endtask

    task automatic send(
        input int lane, input rs_pkg::fu_type_t fu,
        input rs_pkg::preg_t src1, input logic r1, input rs_pkg::preg_t src2, input logic r2,
        output rs_pkg::inst_tag_t tag, output rs_pkg::preg_t dest
    );
        tag = rs_pkg::inst_tag_t'($urandom());
        dest = random_preg();
        disp_valid[lane] <= 1'b1;
        disp_fu_type[lane] <= fu;
        disp_tag[lane] <= tag;
        disp_dest[lane] <= dest;
        disp_src1[lane] <= src1;
        disp_src1_ready[lane] <= r1;
        disp_src2[lane] <= src2;
        disp_src2_ready[lane] <= r2;
    endtask

    task automatic broadcast(input int lane, input rs_pkg::preg_t preg);
        cdb_valid[lane] <= 1'b1;
        cdb_preg[lane] <= preg;
    endtask

    task automatic test_reset();
        settle();
        check_open(open_entries, rs_pkg::open_count_t'(rs_pkg::DISPATCH_WIDTH));
        advance();
    endtask

    task automatic test_ready_pair();
        rs_pkg::inst_tag_t tag0, tag1;
        rs_pkg::preg_t dest0, dest1;
        send(0, rs_pkg::FU_ALU, random_preg(), 1'b1, random_preg(), 1'b1, tag0, dest0);
        send(1, rs_pkg::FU_ALU, random_preg(), 1'b1, random_preg(), 1'b1, tag1, dest1);
        step();
        settle();
        check_issue("alu", 0, alu_issue_valid[0], alu_issue_tag[0], alu_issue_dest[0],
            1'b1, tag0, dest0);
        check_issue("alu", 1, alu_issue_valid[1], alu_issue_tag[1], alu_issue_dest[1],
            1'b1, tag1, dest1);
        advance();
        step();
    endtask

    task automatic test_wakeup();
        rs_pkg::preg_t src_a, src_b, dest0;
        rs_pkg::inst_tag_t tag0;
        src_a = random_preg();
        // differs from src_a in bit 0
        src_b = src_a ^ rs_pkg::preg_t'(1);
        send(0, rs_pkg::FU_ALU, src_a, 1'b0, src_b, 1'b0, tag0, dest0);
        step();
        broadcast(0, src_a);
        step();
        broadcast(1, src_b);
        settle();
        check_issue("alu", 0, alu_issue_valid[0], alu_issue_tag[0], alu_issue_dest[0],
            1'b0, tag0, dest0);
        advance();
        settle();
        check_issue("alu", 0, alu_issue_valid[0], alu_issue_tag[0], alu_issue_dest[0],
            1'b1, tag0, dest0);
        advance();
    endtask

    task automatic test_class_routing();
        rs_pkg::inst_tag_t tag0, tag1;
        rs_pkg::preg_t dest0, dest1;
        mult_busy <= 1'b1;
        send(0, rs_pkg::FU_MULT, random_preg(), 1'b1, random_preg(), 1'b1, tag0, dest0);
        step();
        step();
        settle();
        check_issue("mult", 0, mult_issue_valid[0], mult_issue_tag[0], mult_issue_dest[0],
            1'b0, tag0, dest0);
        advance();
        mult_busy <= 1'b0;
        settle();
        check_issue("mult", 0, mult_issue_valid[0], mult_issue_tag[0], mult_issue_dest[0],
            1'b1, tag0, dest0);
        advance();
        // unit 0 busy, unit 1 serves both entries in slot order
        alu_busy <= 2'b01;
        send(0, rs_pkg::FU_ALU, random_preg(), 1'b1, random_preg(), 1'b1, tag0, dest0);
        send(1, rs_pkg::FU_ALU, random_preg(), 1'b1, random_preg(), 1'b1, tag1, dest1);
        step();
        settle();
        check_issue("alu", 1, alu_issue_valid[1], alu_issue_tag[1], alu_issue_dest[1],
            1'b1, tag0, dest0);
        advance();
        settle();
        check_issue("alu", 1, alu_issue_valid[1], alu_issue_tag[1], alu_issue_dest[1],
            1'b1, tag1, dest1);
        advance();
        alu_busy <= '0;
    endtask

    task automatic test_full_station();
        rs_pkg::inst_tag_t tag;
        rs_pkg::preg_t dest;
        alu_busy <= '1;
        mult_busy <= '1;
        for (int i = 0; i < rs_pkg::RS_DEPTH / rs_pkg::DISPATCH_WIDTH; i++) begin
            for (int lane = 0; lane < rs_pkg::DISPATCH_WIDTH; lane++) begin
                send(lane, rs_pkg::fu_type_t'($urandom()), random_preg(), 1'b1,
                    random_preg(), 1'b1, tag, dest);
            end
            step();
        end
        settle();
        check_open(open_entries, '0);
        advance();
        alu_busy <= '0;
        mult_busy <= '0;
        while (count_free() < rs_pkg::RS_DEPTH) begin
            step();
        end
        settle();
        check_open(open_entries, rs_pkg::open_count_t'(rs_pkg::DISPATCH_WIDTH));
        advance();
    endtask

    initial begin
        void'($urandom(SEED));
        reset <= 1'b1;
        alu_busy <= '0;
        mult_busy <= '0;
        for (int l = 0; l < rs_pkg::DISPATCH_WIDTH; l++) begin
            disp_valid[l] <= 1'b0;
            disp_fu_type[l] <= rs_pkg::FU_ALU;
            disp_tag[l] <= '0;
            disp_dest[l] <= '0;
            disp_src1[l] <= '0;
            disp_src1_ready[l] <= 1'b0;
            disp_src2[l] <= '0;
            disp_src2_ready[l] <= 1'b0;
        end
        for (int l = 0; l < rs_pkg::CDB_WIDTH; l++) begin
            cdb_valid[l] <= 1'b0;
            cdb_preg[l] <= '0;
        end
        for (int s = 0; s < rs_pkg::RS_DEPTH; s++) begin
            model_valid[s] = 1'b0;
        end
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        test_reset();
        test_ready_pair();
        test_wakeup();
        test_class_routing();
        test_full_station();
        $display("Simulation PASSED");
        $finish;
    end

endmodule
